// ==== common/vsi_pkg.sv ====
package vsi_pkg;

    localparam int N_ADC_CHANNELS = 3;
    localparam int ADC_BITS = 12;
    // two leading zeros, then the result msb first
    localparam int SPI_FRAME_BITS = 14;
    localparam int SPI_HALF_PERIOD = 2;
    localparam int SAMPLE_DEPTH = 8;
    localparam int PWM_BITS = 16;

    localparam int REG_ADDR_BITS = 3;
    localparam logic [REG_ADDR_BITS-1:0] REG_CTRL = 3'd0;
    localparam logic [REG_ADDR_BITS-1:0] REG_TB_PERIOD = 3'd1;
    localparam logic [REG_ADDR_BITS-1:0] REG_PWM_PERIOD = 3'd2;
    localparam logic [REG_ADDR_BITS-1:0] REG_DUTY_A = 3'd3;
    localparam logic [REG_ADDR_BITS-1:0] REG_DUTY_B = 3'd4;
    localparam logic [REG_ADDR_BITS-1:0] REG_DUTY_C = 3'd5;
    localparam logic [REG_ADDR_BITS-1:0] REG_SAMPLE = 3'd6;
    localparam logic [REG_ADDR_BITS-1:0] REG_STATUS = 3'd7;

    typedef struct packed {
        logic write;
        logic read;
        logic [REG_ADDR_BITS-1:0] addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic rvalid;
        logic [31:0] rdata;
    } reg_rsp_t;

    // sense_en sits at bit 0
    typedef struct packed {
        logic irq_en;
        logic gates_en;
        logic sense_en;
    } ctrl_t;

    typedef struct packed {
        logic [1:0] channel;
        logic [ADC_BITS-1:0] data;
    } adc_sample_t;

    typedef struct packed {
        logic [PWM_BITS-1:0] period;
        logic [2:0][PWM_BITS-1:0] duty;
    } pwm_cfg_t;

endpackage

// ==== hdl/vsi_regs.sv ====
`timescale 1ns/1ns

module vsi_regs (
    input wire clock,
    input wire arst_n,
    input vsi_pkg::reg_req_t req,
    input vsi_pkg::adc_sample_t buf_head,
    input wire buf_nonempty,
    input wire overrun,
    input wire pwm_sync,
    output vsi_pkg::reg_rsp_t rsp,
    output vsi_pkg::ctrl_t ctrl,
    output logic [31:0] tb_period,
    output vsi_pkg::pwm_cfg_t pwm_cfg,
    output logic pop,
    output logic irq
);
    import vsi_pkg::*;

    logic irq_pending;
    logic overrun_sticky;
    logic status_wr;
    logic [31:0] read_word;

    assign status_wr = req.write && (req.addr == REG_STATUS);
    assign pop = req.read && (req.addr == REG_SAMPLE) && buf_nonempty;
    assign irq = irq_pending;

    always_comb begin
        case (req.addr)
            REG_CTRL: read_word = 32'(ctrl);
            REG_TB_PERIOD: read_word = tb_period;
            REG_PWM_PERIOD: read_word = 32'(pwm_cfg.period);
            REG_DUTY_A: read_word = 32'(pwm_cfg.duty[0]);
            REG_DUTY_B: read_word = 32'(pwm_cfg.duty[1]);
            REG_DUTY_C: read_word = 32'(pwm_cfg.duty[2]);
            // empty buffer reads as zero apart from the flag
            REG_SAMPLE: read_word = {15'd0, buf_nonempty, 2'd0,
                                     buf_nonempty ? buf_head : '0};
            default: read_word = {30'd0, overrun_sticky, irq_pending};
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
            tb_period <= '0;
            pwm_cfg <= '0;
            rsp <= '0;
            irq_pending <= 1'b0;
            overrun_sticky <= 1'b0;
        end else begin
            rsp.rvalid <= req.read;
            if (req.read) begin
                rsp.rdata <= read_word;
            end
            if (req.write) begin
                case (req.addr)
                    REG_CTRL: ctrl <= ctrl_t'(req.wdata[2:0]);
                    REG_TB_PERIOD: tb_period <= req.wdata;
                    REG_PWM_PERIOD: pwm_cfg.period <= req.wdata[PWM_BITS-1:0];
                    REG_DUTY_A: pwm_cfg.duty[0] <= req.wdata[PWM_BITS-1:0];
                    REG_DUTY_B: pwm_cfg.duty[1] <= req.wdata[PWM_BITS-1:0];
                    REG_DUTY_C: pwm_cfg.duty[2] <= req.wdata[PWM_BITS-1:0];
                    default: ;
                endcase
            end
            // a new event wins over a clear in the same cycle
            irq_pending <= (irq_pending & ~(status_wr & req.wdata[0]))
                           | (pwm_sync & ctrl.irq_en);
            overrun_sticky <= (overrun_sticky & ~(status_wr & req.wdata[1])) | overrun;
        end
    end

endmodule

// ==== hdl/sample_timebase.sv ====
`timescale 1ns/1ns

module sample_timebase (
    input wire clock,
    input wire arst_n,
    input wire enable,
    input wire [31:0] period,
    output logic trigger
);

    logic [31:0] count;

    // one pulse every period+1 clocks, counter held at zero while disabled
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            trigger <= 1'b0;
        end else if (!enable) begin
            count <= '0;
            trigger <= 1'b0;
        end else if (count >= period) begin
            count <= '0;
            trigger <= 1'b1;
        end else begin
            count <= count + 32'd1;
            trigger <= 1'b0;
        end
    end

endmodule

// ==== adc/spi_adc_capture.sv ====
`timescale 1ns/1ns

module spi_adc_capture (
    input wire clock,
    input wire arst_n,
    input wire trigger,
    input wire [vsi_pkg::N_ADC_CHANNELS-1:0] miso,
    input wire credit_return,
    output logic spi_clk,
    output logic spi_cs,
    output logic sample_valid,
    output vsi_pkg::adc_sample_t sample,
    output logic overrun
);
    import vsi_pkg::*;

    localparam int EDGES = 2 * SPI_FRAME_BITS;
    localparam int EDGE_W = $clog2(EDGES);
    localparam int DIV_W = $clog2(SPI_HALF_PERIOD + 1);
    localparam int CRED_W = $clog2(SAMPLE_DEPTH + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_FRAME, ST_UNLOAD} state_t;

    state_t state;
    logic [DIV_W-1:0] div_cnt;
    logic [EDGE_W-1:0] edge_cnt;
    logic [1:0] ch_idx;
    logic [CRED_W-1:0] credits;
    logic [N_ADC_CHANNELS-1:0][ADC_BITS-1:0] shreg;
    logic half_done;

    assign half_done = (div_cnt == DIV_W'(SPI_HALF_PERIOD - 1));
    assign sample_valid = (state == ST_UNLOAD) && (credits != '0);
    assign sample.channel = ch_idx;
    assign sample.data = shreg[ch_idx];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            spi_cs <= 1'b1;
            spi_clk <= 1'b1;
            div_cnt <= '0;
            edge_cnt <= '0;
            ch_idx <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (trigger && credits >= CRED_W'(N_ADC_CHANNELS)) begin
                        state <= ST_FRAME;
                        spi_cs <= 1'b0;
                        div_cnt <= '0;
                        edge_cnt <= '0;
                    end else if (trigger) begin
                        overrun <= 1'b1;
                    end
                end
                ST_FRAME: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        spi_clk <= ~spi_clk;
                        edge_cnt <= edge_cnt + 1'b1;
                        // last rising edge closes the frame
                        if (!spi_clk && edge_cnt == EDGE_W'(EDGES - 1)) begin
                            state <= ST_UNLOAD;
                            spi_cs <= 1'b1;
                            ch_idx <= '0;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: begin
                    if (sample_valid) begin
                        if (ch_idx == 2'(N_ADC_CHANNELS - 1)) begin
                            state <= ST_IDLE;
                        end else begin
                            ch_idx <= ch_idx + 2'd1;
                        end
                    end
                end
            endcase
        end
    end

    // miso taken as sclk goes high, leading zeros drop out the top
    always_ff @(posedge clock) begin
        if (state == ST_FRAME && half_done && !spi_clk) begin
            for (int ch = 0; ch < N_ADC_CHANNELS; ch++) begin
                shreg[ch] <= {shreg[ch][ADC_BITS-2:0], miso[ch]};
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRED_W'(SAMPLE_DEPTH);
        end else begin
            case ({credit_return, sample_valid})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== adc/sample_buffer.sv ====
`timescale 1ns/1ns

module sample_buffer (
    input wire clock,
    input wire arst_n,
    input wire sample_valid,
    input vsi_pkg::adc_sample_t sample,
    input wire pop,
    output vsi_pkg::adc_sample_t head,
    output logic nonempty,
    output logic credit_return
);
    import vsi_pkg::*;

    localparam int PTR_W = $clog2(SAMPLE_DEPTH);

    adc_sample_t mem [SAMPLE_DEPTH];
    // extra msb tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    assign nonempty = (wr_ptr != rd_ptr);
    assign head = mem[rd_ptr[PTR_W-1:0]];

    // room is guaranteed by the sender's credits
    always_ff @(posedge clock) begin
        if (sample_valid) begin
            mem[wr_ptr[PTR_W-1:0]] <= sample;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop && nonempty;
            if (sample_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && nonempty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/pwm_generator.sv ====
`timescale 1ns/1ns

module pwm_generator (
    input wire clock,
    input wire arst_n,
    input vsi_pkg::pwm_cfg_t cfg,
    input wire gates_en,
    output logic [2:0] gates,
    output logic pwm_sync
);
    import vsi_pkg::*;

    pwm_cfg_t cfg_sh;
    logic [PWM_BITS-1:0] count;
    logic last;

    // also true for a zero period, so new settings can still load
    assign last = ({1'b0, count} + 1'b1) >= {1'b0, cfg_sh.period};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            cfg_sh <= '0;
            pwm_sync <= 1'b0;
        end else if (last) begin
            count <= '0;
            cfg_sh <= cfg;
            pwm_sync <= 1'b1;
        end else begin
            count <= count + 1'b1;
            pwm_sync <= 1'b0;
        end
    end

    always_comb begin
        for (int ph = 0; ph < 3; ph++) begin
            gates[ph] = gates_en && (count < cfg_sh.duty[ph]);
        end
    end

endmodule

// ==== hdl/simple_vsi_logic.sv ====
`timescale 1ns/1ns

module simple_vsi_logic (
    input wire clock,
    input wire arst_n,
    input vsi_pkg::reg_req_t req,
    input wire [2:0] ph_spi_data,
    output vsi_pkg::reg_rsp_t rsp,
    output wire irq,
    output wire gate_a,
    output wire gate_b,
    output wire gate_c,
    output wire gates_en,
    output wire ph_spi_clk,
    output wire ph_spi_cs,
    output wire user_led_a,
    output wire user_led_b
);
    import vsi_pkg::*;

    ctrl_t ctrl;
    pwm_cfg_t pwm_cfg;
    adc_sample_t sample;
    adc_sample_t buf_head;
    logic [31:0] tb_period;
    logic [2:0] gates;
    logic trigger;
    logic overrun;
    logic sample_valid;
    logic credit_return;
    logic pop;
    logic buf_nonempty;
    logic pwm_sync;

    vsi_regs regs (
        .clock(clock),
        .arst_n(arst_n),
        .req(req),
        .buf_head(buf_head),
        .buf_nonempty(buf_nonempty),
        .overrun(overrun),
        .pwm_sync(pwm_sync),
        .rsp(rsp),
        .ctrl(ctrl),
        .tb_period(tb_period),
        .pwm_cfg(pwm_cfg),
        .pop(pop),
        .irq(irq)
    );

    sample_timebase ph_timebase (
        .clock(clock),
        .arst_n(arst_n),
        .enable(ctrl.sense_en),
        .period(tb_period),
        .trigger(trigger)
    );

    spi_adc_capture ph_adc (
        .clock(clock),
        .arst_n(arst_n),
        .trigger(trigger),
        .miso(ph_spi_data),
        .credit_return(credit_return),
        .spi_clk(ph_spi_clk),
        .spi_cs(ph_spi_cs),
        .sample_valid(sample_valid),
        .sample(sample),
        .overrun(overrun)
    );

    sample_buffer samples (
        .clock(clock),
        .arst_n(arst_n),
        .sample_valid(sample_valid),
        .sample(sample),
        .pop(pop),
        .head(buf_head),
        .nonempty(buf_nonempty),
        .credit_return(credit_return)
    );

    pwm_generator gen (
        .clock(clock),
        .arst_n(arst_n),
        .cfg(pwm_cfg),
        .gates_en(ctrl.gates_en),
        .gates(gates),
        .pwm_sync(pwm_sync)
    );

    assign gate_a = gates[0];
    assign gate_b = gates[1];
    assign gate_c = gates[2];
    assign gates_en = ctrl.gates_en;

    assign user_led_a = ctrl.sense_en;
    assign user_led_b = ctrl.gates_en;

endmodule

// ==== tb/adc_model.sv ====
`timescale 1ns/1ns

module adc_model (
    input wire spi_clk,
    input wire spi_cs,
    output logic [vsi_pkg::N_ADC_CHANNELS-1:0] miso
);
    import vsi_pkg::*;

    logic [31:0] seed;
    logic [N_ADC_CHANNELS-1:0][SPI_FRAME_BITS-1:0] words;
    int bit_idx;
    // every value sent, in the order the buffer should hand them back
    logic [ADC_BITS-1:0] values[$];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        seed = 32'hded2;
        miso = '0;
        bit_idx = -1;
    end

    // sclk idles high, so a falling edge with sclk still high is chip select
    always @(negedge spi_cs or negedge spi_clk) begin
        if (spi_clk) begin
            for (int ch = 0; ch < N_ADC_CHANNELS; ch++) begin
                seed = xorshift(seed);
                words[ch] = SPI_FRAME_BITS'(seed[ADC_BITS-1:0]);
                values.push_back(seed[ADC_BITS-1:0]);
            end
            bit_idx = SPI_FRAME_BITS - 1;
        end else if (!spi_cs && bit_idx >= 0) begin
            for (int ch = 0; ch < N_ADC_CHANNELS; ch++) begin
                miso[ch] <= words[ch][bit_idx];
            end
            bit_idx = bit_idx - 1;
        end
    end

endmodule

// ==== tb/vsi_tb.sv ====
`timescale 1ns/1ns

module vsi_tb;
    import vsi_pkg::*;

    localparam int PWM_PERIOD_CYC = 20;
    localparam int DUTY_STEP = 5;
    // budgets of reset, registers, stream, back-pressure, pwm and irq tests
    localparam int CYCLE_LIMIT = 2 * (40 + 120 + 600 + 700 + 500 + 300);

    logic clock;
    logic arst_n;
    reg_req_t req;
    reg_rsp_t rsp;
    wire [2:0] ph_spi_data;
    wire irq, gate_a, gate_b, gate_c, gates_en;
    wire ph_spi_clk, ph_spi_cs, user_led_a, user_led_b;

    int cycles = 0;
    int errors = 0;
    int errors_at_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int next_channel = 0;
    string test_name;

    simple_vsi_logic dut (
        .clock(clock),
        .arst_n(arst_n),
        .req(req),
        .ph_spi_data(ph_spi_data),
        .rsp(rsp),
        .irq(irq),
        .gate_a(gate_a),
        .gate_b(gate_b),
        .gate_c(gate_c),
        .gates_en(gates_en),
        .ph_spi_clk(ph_spi_clk),
        .ph_spi_cs(ph_spi_cs),
        .user_led_a(user_led_a),
        .user_led_b(user_led_b)
    );

    adc_model model (
        .spi_clk(ph_spi_clk),
        .spi_cs(ph_spi_cs),
        .miso(ph_spi_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s: %s expected 0x%h actual 0x%h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic write_reg(input logic [REG_ADDR_BITS-1:0] address, input logic [31:0] data);
        @(posedge clock);
        req <= '{write: 1'b1, read: 1'b0, addr: address, wdata: data};
        @(posedge clock);
        req <= '0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_BITS-1:0] address, output logic [31:0] data);
        @(posedge clock);
        req <= '{write: 1'b0, read: 1'b1, addr: address, wdata: 32'd0};
        @(negedge clock);
        check_value("rvalid in request cycle", 32'd0, 32'(rsp.rvalid));
        @(posedge clock);
        req <= '0;
        @(negedge clock);
        check_value("rvalid one cycle after read", 32'd1, 32'(rsp.rvalid));
        data = rsp.rdata;
    endtask

    task automatic read_check(input logic [REG_ADDR_BITS-1:0] address,
                              input logic [31:0] expected, input string what);
        logic [31:0] data;
        read_reg(address, data);
        check_value(what, expected, data);
    endtask

    task automatic read_sample(output logic got);
        logic [31:0] word;
        logic [ADC_BITS-1:0] expected;
        read_reg(REG_SAMPLE, word);
        got = word[16];
        if (got) begin
            check_value("sample channel", 32'(next_channel), 32'(word[13:12]));
            next_channel = (next_channel + 1) % N_ADC_CHANNELS;
            assert (model.values.size() > 0) else begin
                $display("%s: buffer returned a sample the ADC never sent", test_name);
                errors++;
            end
            if (model.values.size() > 0) begin
                expected = model.values.pop_front();
                check_value("sample data", 32'(expected), 32'(word[11:0]));
            end
        end
    endtask

    task automatic collect_samples(input int count);
        logic got;
        int seen;
        seen = 0;
        while (seen < count) begin
            read_sample(got);
            if (got) begin
                seen++;
            end
        end
    endtask

    // stops sensing, lets a running frame finish, then empties the buffer
    task automatic stop_and_drain();
        logic got;
        write_reg(REG_CTRL, 32'd0);
        repeat (2) @(posedge clock);
        @(negedge clock);
        wait (ph_spi_cs === 1'b1);
        repeat (2 * N_ADC_CHANNELS) @(posedge clock);
        got = 1'b1;
        while (got) begin
            read_sample(got);
        end
        check_value("model values never read", 32'd0, 32'(model.values.size()));
    endtask

    function automatic logic probe(input int idx);
        logic [3:0] sigs;
        sigs = {irq, gate_c, gate_b, gate_a};
        return sigs[idx];
    endfunction

    task automatic wait_level(input int idx, input logic level, output int when);
        @(negedge clock);
        while (probe(idx) !== level) begin
            @(negedge clock);
        end
        when = cycles;
    endtask

    task automatic measure_gate(input int idx, output int high, output int period);
        int t_low;
        int t_rise;
        int t_fall;
        int t_next;
        wait_level(idx, 1'b0, t_low);
        wait_level(idx, 1'b1, t_rise);
        wait_level(idx, 1'b0, t_fall);
        wait_level(idx, 1'b1, t_next);
        high = t_fall - t_rise;
        period = t_next - t_rise;
    endtask

    initial begin
        logic got;
        logic [31:0] status;
        int t_rise;
        int t_fall;
        int t_irq;
        int high;
        int period;

        req = '0;
        arst_n = 1'b0;
        begin_test("reset_values");
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        // cs, sclk, rvalid, gates c..a, gates_en, irq, leds
        check_value("pins after reset", 32'b11_0000_0000,
                    32'({ph_spi_cs, ph_spi_clk, rsp.rvalid, gate_c, gate_b, gate_a,
                         gates_en, irq, user_led_a, user_led_b}));
        end_test();

        begin_test("register_access");
        write_reg(REG_TB_PERIOD, 32'h1234_5678);
        read_check(REG_TB_PERIOD, 32'h1234_5678, "timebase period");
        write_reg(REG_PWM_PERIOD, 32'h40);
        read_check(REG_PWM_PERIOD, 32'h40, "pwm period");
        write_reg(REG_DUTY_A, 32'h10);
        write_reg(REG_DUTY_B, 32'h20);
        write_reg(REG_DUTY_C, 32'h30);
        read_check(REG_DUTY_A, 32'h10, "duty a");
        read_check(REG_DUTY_B, 32'h20, "duty b");
        read_check(REG_DUTY_C, 32'h30, "duty c");
        write_reg(REG_CTRL, 32'd1);
        read_check(REG_CTRL, 32'd1, "ctrl with sense");
        check_value("led a, gates_en, led b", 32'b100, 32'({user_led_a, gates_en, user_led_b}));
        write_reg(REG_CTRL, 32'd2);
        read_check(REG_CTRL, 32'd2, "ctrl with gates");
        check_value("led a, gates_en, led b", 32'b011, 32'({user_led_a, gates_en, user_led_b}));
        write_reg(REG_CTRL, 32'd0);
        end_test();

        begin_test("sample_stream");
        read_sample(got);
        check_value("nonempty flag of empty buffer", 32'd0, 32'(got));
        write_reg(REG_TB_PERIOD, 32'd99);
        write_reg(REG_CTRL, 32'd1);
        collect_samples(3 * N_ADC_CHANNELS);
        stop_and_drain();
        end_test();

        begin_test("back_pressure");
        write_reg(REG_TB_PERIOD, 32'd9);
        write_reg(REG_CTRL, 32'd1);
        status = '0;
        while (!status[1]) begin
            read_reg(REG_STATUS, status);
        end
        write_reg(REG_CTRL, 32'd0);
        for (int i = 0; i < 2 * N_ADC_CHANNELS; i++) begin
            read_sample(got);
            check_value("buffered sample present", 32'd1, 32'(got));
        end
        read_sample(got);
        check_value("nonempty flag after two frames", 32'd0, 32'(got));
        check_value("model frames beyond two", 32'd0, 32'(model.values.size()));
        write_reg(REG_STATUS, 32'h2);
        read_reg(REG_STATUS, status);
        check_value("overrun after clear", 32'd0, 32'(status[1]));
        write_reg(REG_TB_PERIOD, 32'd99);
        write_reg(REG_CTRL, 32'd1);
        collect_samples(N_ADC_CHANNELS);
        stop_and_drain();
        end_test();

        begin_test("pwm_gates");
        write_reg(REG_PWM_PERIOD, 32'(PWM_PERIOD_CYC));
        write_reg(REG_DUTY_A, 32'(DUTY_STEP));
        write_reg(REG_DUTY_B, 32'(2 * DUTY_STEP));
        write_reg(REG_DUTY_C, 32'(3 * DUTY_STEP));
        write_reg(REG_CTRL, 32'd2);
        // the first pulse may be cut short by the enable
        wait_level(0, 1'b1, t_rise);
        wait_level(0, 1'b0, t_fall);
        for (int ph = 0; ph < 3; ph++) begin
            measure_gate(ph, high, period);
            check_value($sformatf("phase %0d high time", ph), 32'(DUTY_STEP * (ph + 1)),
                        32'(high));
            check_value($sformatf("phase %0d period", ph), 32'(PWM_PERIOD_CYC), 32'(period));
        end
        wait_level(0, 1'b1, t_rise);
        wait_level(0, 1'b0, t_fall);
        write_reg(REG_DUTY_A, 32'd12);
        wait_level(0, 1'b1, t_rise);
        check_value("low time while duty changes", 32'(PWM_PERIOD_CYC - DUTY_STEP),
                    32'(t_rise - t_fall));
        wait_level(0, 1'b0, t_fall);
        check_value("high time after duty change", 32'd12, 32'(t_fall - t_rise));
        write_reg(REG_CTRL, 32'd0);
        repeat (2 * PWM_PERIOD_CYC) begin
            @(negedge clock);
            check_value("gates while disabled", 32'd0, 32'({gates_en, gate_c, gate_b, gate_a}));
        end
        end_test();

        begin_test("pwm_irq");
        write_reg(REG_CTRL, 32'd2);
        wait_level(0, 1'b0, t_fall);
        wait_level(0, 1'b1, t_rise);
        write_reg(REG_CTRL, 32'd6);
        @(negedge clock);
        check_value("irq before wrap", 32'd0, 32'(irq));
        read_check(REG_CTRL, 32'd6, "ctrl with irq and gates");
        wait_level(0, 1'b0, t_fall);
        wait_level(0, 1'b1, t_rise);
        wait_level(3, 1'b1, t_irq);
        check_value("irq delay after wrap", 32'd1, 32'(t_irq - t_rise));
        repeat (2 * PWM_PERIOD_CYC) begin
            @(negedge clock);
            check_value("irq held", 32'd1, 32'(irq));
        end
        read_reg(REG_STATUS, status);
        check_value("irq pending in status", 32'd1, 32'(status[0]));
        wait_level(0, 1'b0, t_fall);
        wait_level(0, 1'b1, t_rise);
        write_reg(REG_CTRL, 32'd2);
        write_reg(REG_STATUS, 32'h1);
        read_reg(REG_STATUS, status);
        check_value("irq pending after clear", 32'd0, 32'(status[0]));
        repeat (2 * PWM_PERIOD_CYC) begin
            @(negedge clock);
            check_value("irq with irq_en off", 32'd0, 32'(irq));
        end
        write_reg(REG_CTRL, 32'd0);
        end_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/vsi_pkg.sv
hdl/vsi_regs.sv
hdl/sample_timebase.sv
adc/spi_adc_capture.sv
adc/sample_buffer.sv
hdl/pwm_generator.sv
hdl/simple_vsi_logic.sv
tb/adc_model.sv
tb/vsi_tb.sv
